/* build.f */
common/conv_mem_pkg.sv
window/window_addr_gen.sv
window/pixel_mem.sv
window/window_gather.sv
source/window_ctrl.sv
source/conv_sample_mem.sv
tb/conv_sample_mem_assertions.sv
tb/conv_sample_mem_tb.sv

/* common/conv_mem_pkg.sv */
package conv_mem_pkg;

  //////////////////////////////
  // geometry
  //////////////////////////////

  // one pixel is a 4 bit intensity
  localparam int PIXEL_W    = 4;

  // square image, row-major in memory
  localparam int IMG_COLS   = 16;
  localparam int IMG_ROWS   = 16;
  localparam int ROW_STRIDE = IMG_COLS;
  localparam int IMG_PIXELS = IMG_COLS * IMG_ROWS;
  localparam int ADDR_W     = $clog2(IMG_PIXELS);
  localparam int LAST_ADDR  = IMG_PIXELS - 1;

  // read window, 4 rows of 4 adjacent pixels
  localparam int WIN_ROWS   = 4;
  localparam int WIN_COLS   = 4;
  localparam int WIN_PIXELS = WIN_ROWS * WIN_COLS;

  //////////////////////////////
  // types
  //////////////////////////////

  typedef logic [PIXEL_W-1:0]          pixel_t;
  typedef logic [ADDR_W-1:0]           pix_addr_t;
  // column 0 sits in the top nibble
  typedef logic [WIN_COLS*PIXEL_W-1:0] win_row_t;

  // row0 in the upper bits of the bus
  typedef struct packed {
    win_row_t row0;
    win_row_t row1;
    win_row_t row2;
    win_row_t row3;
  } window_t;

  // index is row * WIN_COLS + col
  typedef pix_addr_t [WIN_PIXELS-1:0] win_addrs_t;
  typedef pixel_t    [WIN_PIXELS-1:0] win_pixels_t;

  // base whose window ends on the last image address
  localparam pix_addr_t LAST_WIN_BASE =
    pix_addr_t'(LAST_ADDR - (WIN_ROWS - 1) * ROW_STRIDE - (WIN_COLS - 1));

  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,
    OP_WRITE = 2'd1,
    OP_READ  = 2'd2
  } cmd_op_t;

  // registered host command
  typedef struct packed {
    cmd_op_t   op;
    pix_addr_t addr;
    pixel_t    pixel;
  } mem_cmd_t;

endpackage

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module conv_sample_mem_tb -f build.f

output=$(./obj_dir/Vconv_sample_mem_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
else
  exit 1
fi

/* source/conv_sample_mem.sv */
module conv_sample_mem (
  input  logic                  clk,
  input  logic                  rst,
  // host command
  input  logic                  ena,
  input  logic                  wr,
  input  logic                  rd,
  input  conv_mem_pkg::pix_addr_t addr,
  input  conv_mem_pkg::pixel_t    pixel,
  // window result
  output conv_mem_pkg::window_t   window,
  output logic                  window_valid,
  output logic                  ack
);

  //////////////////////////////
  // internal nets
  //////////////////////////////

  conv_mem_pkg::mem_cmd_t    cmd;
  conv_mem_pkg::win_addrs_t  addrs;
  conv_mem_pkg::win_pixels_t pixels;
  logic                      capture;

  // host handshake, command register, flags
  window_ctrl i_ctrl (
    .clk          (clk),
    .rst          (rst),
    .ena          (ena),
    .wr           (wr),
    .rd           (rd),
    .addr         (addr),
    .pixel        (pixel),
    .cmd          (cmd),
    .capture      (capture),
    .window_valid (window_valid),
    .ack          (ack)
  );

  // all 16 window addresses from the base
  window_addr_gen i_addr_gen (
    .base  (cmd.addr),
    .addrs (addrs)
  );

  // image store
  pixel_mem i_mem (
    .clk    (clk),
    .cmd    (cmd),
    .addrs  (addrs),
    .pixels (pixels)
  );

  // output window register
  window_gather i_gather (
    .clk     (clk),
    .rst     (rst),
    .capture (capture),
    .pixels  (pixels),
    .window  (window)
  );

endmodule

/* source/window_ctrl.sv */
module window_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ena,
  input  logic                    wr,
  input  logic                    rd,
  input  conv_mem_pkg::pix_addr_t addr,
  input  conv_mem_pkg::pixel_t    pixel,
  output conv_mem_pkg::mem_cmd_t  cmd,
  output logic                    capture,
  output logic                    window_valid,
  output logic                    ack
);

  //////////////////////////////
  // command decode
  //////////////////////////////

  conv_mem_pkg::cmd_op_t  op_dec;
  conv_mem_pkg::mem_cmd_t cmd_next;
  logic                   base_is_last;

  // write beats read when both are set
  always_comb
  begin
    if (ena && wr)
    begin
      op_dec = conv_mem_pkg::OP_WRITE;
    end
    else if (ena && rd)
    begin
      op_dec = conv_mem_pkg::OP_READ;
    end
    else
    begin
      op_dec = conv_mem_pkg::OP_IDLE;
    end
  end

  assign cmd_next = '{op: op_dec, addr: addr, pixel: pixel};

  // one command per cycle, no stall
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cmd <= '{op: conv_mem_pkg::OP_IDLE, addr: '0, pixel: '0};
    end
    else
    begin
      cmd <= cmd_next;
    end
  end

  //////////////////////////////
  // output flags
  //////////////////////////////

  // read in flight this cycle
  assign capture      = (cmd.op == conv_mem_pkg::OP_READ);
  // window ends on the last pixel
  assign base_is_last = (cmd.addr == conv_mem_pkg::LAST_WIN_BASE);

  // flags line up with the window register
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      window_valid <= 1'b0;
      ack          <= 1'b0;
    end
    else
    begin
      window_valid <= capture;
      ack          <= capture && base_is_last;
    end
  end

endmodule

/* tb/conv_sample_mem_assertions.sv */
module conv_sample_mem_assertions (
  input logic                  clk,
  input logic                  rst,
  input logic                  ena,
  input logic                  wr,
  input logic                  rd,
  input conv_mem_pkg::window_t window,
  input logic                  window_valid,
  input logic                  ack
);

  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////
  // flag relations
  //////////////////////////////

  // ack only with a valid window
  a_ack_needs_valid : assert property (@(posedge clk) disable iff (rst)
    ack |-> window_valid)
    else $error("ack is high without window_valid");

  // idle window reads as zero
  a_window_zero_idle : assert property (@(posedge clk) disable iff (rst)
    !window_valid |-> (window == '0))
    else $error("window is not zero while window_valid is low");

  // host read sampled at one edge, valid registered at the next
  a_valid_after_read : assert property (@(posedge clk) disable iff (rst)
    (ena && rd && !wr) |-> ##2 window_valid)
    else $error("window_valid missing after a read");

  // and nothing without a read
  a_no_valid_without_read : assert property (@(posedge clk) disable iff (rst)
    !(ena && rd && !wr) |-> ##2 !window_valid)
    else $error("window_valid raised without a read");

endmodule

bind conv_sample_mem conv_sample_mem_assertions i_assertions (
  .clk          (clk),
  .rst          (rst),
  .ena          (ena),
  .wr           (wr),
  .rd           (rd),
  .window       (window),
  .window_valid (window_valid),
  .ack          (ack)
);

/* tb/conv_sample_mem_tb.sv */
module conv_sample_mem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////
  // run constants
  //////////////////////////////

  localparam int NUM_STEPS   = 21;
  // full fill, table, some slack, doubled
  localparam int CYCLE_LIMIT = 2 * (conv_mem_pkg::IMG_PIXELS + NUM_STEPS + 20);

  // one table row with host command and expected flags
  typedef struct packed {
    logic                    ena;
    logic                    wr;
    logic                    rd;
    conv_mem_pkg::pix_addr_t addr;
    conv_mem_pkg::pixel_t    pixel;
    logic                    exp_valid;
    logic                    exp_ack;
  } step_t;

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    ena;
  logic                    wr;
  logic                    rd;
  conv_mem_pkg::pix_addr_t addr;
  conv_mem_pkg::pixel_t    pixel;
  conv_mem_pkg::window_t   window;
  logic                    window_valid;
  logic                    ack;

  // reference image
  conv_mem_pkg::pixel_t  model [conv_mem_pkg::IMG_PIXELS];
  step_t                 steps [NUM_STEPS];
  conv_mem_pkg::window_t exp_window [NUM_STEPS];
  integer                seed = 94233;
  int                    error_count = 0;
  int                    check_count = 0;
  int                    cycle_count = 0;

  conv_sample_mem i_dut (
    .clk          (clk),
    .rst          (rst),
    .ena          (ena),
    .wr           (wr),
    .rd           (rd),
    .addr         (addr),
    .pixel        (pixel),
    .window       (window),
    .window_valid (window_valid),
    .ack          (ack)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // hard stop in case the sequence stalls
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic drive_cmd(input logic e, input logic w, input logic r,
                           input conv_mem_pkg::pix_addr_t a, input conv_mem_pkg::pixel_t p);
    ena   = e;
    wr    = w;
    rd    = r;
    addr  = a;
    pixel = p;
  endtask

  // model window with row0 col0 in the top nibble
  function automatic conv_mem_pkg::window_t model_window(input conv_mem_pkg::pix_addr_t base);
    logic [63:0]             flat;
    conv_mem_pkg::pix_addr_t a;
    flat = '0;
    for (int r = 0; r < 4; r++)
    begin
      for (int c = 0; c < 4; c++)
      begin
        // 8 bit sum wraps past the last pixel
        a    = base + conv_mem_pkg::pix_addr_t'(r * conv_mem_pkg::ROW_STRIDE + c);
        flat = {flat[59:0], model[a]};
      end
    end
    return conv_mem_pkg::window_t'(flat);
  endfunction

  function automatic step_t make_step(input logic e, input logic w, input logic r,
                                      input conv_mem_pkg::pix_addr_t a,
                                      input conv_mem_pkg::pixel_t p,
                                      input logic v, input logic k);
    return '{ena: e, wr: w, rd: r, addr: a, pixel: p, exp_valid: v, exp_ack: k};
  endfunction

  // write data is the inverse of the filled pixel so every write shows
  task automatic load_table();
    steps[0]  = make_step(1'b0, 1'b0, 1'b0, 8'd0,   4'h0,        1'b0, 1'b0);
    // interior reads
    steps[1]  = make_step(1'b1, 1'b0, 1'b1, 8'd34,  4'h0,        1'b1, 1'b0);
    steps[2]  = make_step(1'b1, 1'b0, 1'b1, 8'd100, 4'h0,        1'b1, 1'b0);
    // windows running off the image end
    steps[3]  = make_step(1'b1, 1'b0, 1'b1, 8'd250, 4'h0,        1'b1, 1'b0);
    steps[4]  = make_step(1'b1, 1'b0, 1'b1, 8'd240, 4'h0,        1'b1, 1'b0);
    // write then a read covering it at 51 = 34 + 16 + 1
    steps[5]  = make_step(1'b1, 1'b1, 1'b0, 8'd51,  ~model[51],  1'b0, 1'b0);
    steps[6]  = make_step(1'b1, 1'b0, 1'b1, 8'd34,  4'h0,        1'b1, 1'b0);
    // wr and rd together is a write to 68 = 34 + 32 + 2
    steps[7]  = make_step(1'b1, 1'b1, 1'b1, 8'd68,  ~model[68],  1'b0, 1'b0);
    steps[8]  = make_step(1'b1, 1'b0, 1'b1, 8'd34,  4'h0,        1'b1, 1'b0);
    // last window base and its neighbours
    steps[9]  = make_step(1'b1, 1'b0, 1'b1, 8'd204, 4'h0,        1'b1, 1'b1);
    steps[10] = make_step(1'b1, 1'b0, 1'b1, 8'd205, 4'h0,        1'b1, 1'b0);
    steps[11] = make_step(1'b1, 1'b0, 1'b1, 8'd203, 4'h0,        1'b1, 1'b0);
    // ena low is ignored
    steps[12] = make_step(1'b0, 1'b0, 1'b1, 8'd10,  4'h0,        1'b0, 1'b0);
    steps[13] = make_step(1'b0, 1'b1, 1'b0, 8'd0,   ~model[0],   1'b0, 1'b0);
    // back to back reads
    steps[14] = make_step(1'b1, 1'b0, 1'b1, 8'd0,   4'h0,        1'b1, 1'b0);
    steps[15] = make_step(1'b1, 1'b0, 1'b1, 8'd1,   4'h0,        1'b1, 1'b0);
    steps[16] = make_step(1'b1, 1'b0, 1'b1, 8'd2,   4'h0,        1'b1, 1'b0);
    steps[17] = make_step(1'b1, 1'b0, 1'b1, 8'd3,   4'h0,        1'b1, 1'b0);
    steps[18] = make_step(1'b1, 1'b1, 1'b0, 8'd204, ~model[204], 1'b0, 1'b0);
    steps[19] = make_step(1'b1, 1'b0, 1'b1, 8'd204, 4'h0,        1'b1, 1'b1);
    steps[20] = make_step(1'b0, 1'b0, 1'b0, 8'd0,   4'h0,        1'b0, 1'b0);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    int rnd;
    rst = 1'b1;
    drive_cmd(1'b0, 1'b0, 1'b0, '0, '0);
    repeat (5) @(posedge clk);
    #2 rst = 1'b0;

    // quiet outputs after reset
    repeat (3)
    begin
      @(posedge clk);
      #2;
      check_value("window_valid", 64'(window_valid), 64'd0);
      check_value("ack", 64'(ack), 64'd0);
      check_value("window", 64'(window), 64'd0);
    end

    // fill every address with random data
    for (int i = 0; i < conv_mem_pkg::IMG_PIXELS; i++)
    begin
      rnd = $random(seed);
      drive_cmd(1'b1, 1'b1, 1'b0, conv_mem_pkg::pix_addr_t'(i), rnd[3:0]);
      model[i] = rnd[3:0];
      @(posedge clk);
      #2;
    end

    load_table();

    // results lag the command by two edges
    for (int n = 0; n < NUM_STEPS + 2; n++)
    begin
      if (n >= 2)
      begin
        check_value("window_valid", 64'(window_valid), 64'(steps[n-2].exp_valid));
        check_value("ack", 64'(ack), 64'(steps[n-2].exp_ack));
        check_value("window", 64'(window), 64'(exp_window[n-2]));
      end
      if (n < NUM_STEPS)
      begin
        exp_window[n] = steps[n].exp_valid ? model_window(steps[n].addr) : '0;
        if (steps[n].ena && steps[n].wr)
        begin
          model[steps[n].addr] = steps[n].pixel;
        end
        drive_cmd(steps[n].ena, steps[n].wr, steps[n].rd, steps[n].addr, steps[n].pixel);
      end
      else
      begin
        drive_cmd(1'b0, 1'b0, 1'b0, '0, '0);
      end
      @(posedge clk);
      #2;
    end

    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* window/pixel_mem.sv */
module pixel_mem (
  input  logic                      clk,
  input  conv_mem_pkg::mem_cmd_t    cmd,
  input  conv_mem_pkg::win_addrs_t  addrs,
  output conv_mem_pkg::win_pixels_t pixels
);

  //////////////////////////////
  // storage
  //////////////////////////////

  // whole image, one pixel per entry
  conv_mem_pkg::pixel_t mem [conv_mem_pkg::IMG_PIXELS];

  // single write port
  always_ff @(posedge clk)
  begin
    if (cmd.op == conv_mem_pkg::OP_WRITE)
    begin
      mem[cmd.addr] <= cmd.pixel;
    end
  end

  //////////////////////////////
  // read ports
  //////////////////////////////

  // one async read per window pixel
  // a read issued right after a write sees the new pixel
  for (genvar i = 0; i < conv_mem_pkg::WIN_PIXELS; i++)
  begin : g_rd
    assign pixels[i] = mem[addrs[i]];
  end

endmodule

/* window/window_addr_gen.sv */
module window_addr_gen (
  input  conv_mem_pkg::pix_addr_t  base,
  output conv_mem_pkg::win_addrs_t addrs
);

  //////////////////////////////
  // window address table
  //////////////////////////////

  // rows one stride apart, columns adjacent
  // sums wrap at ADDR_W, so a window may run off the end of the image
  for (genvar r = 0; r < conv_mem_pkg::WIN_ROWS; r++)
  begin : g_row
    for (genvar c = 0; c < conv_mem_pkg::WIN_COLS; c++)
    begin : g_col
      // fixed offset of this pixel from the base
      localparam int OFFSET = r * conv_mem_pkg::ROW_STRIDE + c;
      localparam int IDX    = r * conv_mem_pkg::WIN_COLS + c;

      assign addrs[IDX] = base + conv_mem_pkg::pix_addr_t'(OFFSET);
    end
  end

endmodule

/* window/window_gather.sv */
module window_gather (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      capture,
  input  conv_mem_pkg::win_pixels_t pixels,
  output conv_mem_pkg::window_t     window
);

  //////////////////////////////
  // row packing
  //////////////////////////////

  conv_mem_pkg::win_row_t rows [conv_mem_pkg::WIN_ROWS];
  conv_mem_pkg::window_t  window_next;

  // col 0 into the top nibble of each row
  always_comb
  begin
    for (int r = 0; r < conv_mem_pkg::WIN_ROWS; r++)
    begin
      for (int c = 0; c < conv_mem_pkg::WIN_COLS; c++)
      begin
        rows[r][(conv_mem_pkg::WIN_COLS-1-c)*conv_mem_pkg::PIXEL_W +: conv_mem_pkg::PIXEL_W] =
          pixels[r*conv_mem_pkg::WIN_COLS + c];
      end
    end
  end

  assign window_next = '{row0: rows[0], row1: rows[1], row2: rows[2], row3: rows[3]};

  //////////////////////////////
  // output register
  //////////////////////////////

  // holds a window for one cycle only, zero otherwise
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      window <= '0;
    end
    else if (capture)
    begin
      window <= window_next;
    end
    else
    begin
      window <= '0;
    end
  end

endmodule
